// ==== hdl/rtcPkg.sv ====
`default_nettype none

package rtcPkg;

	// one BCD field, two digits
	localparam int DATA_W = 8;
	localparam int FIELD_W = 2;
	localparam int PAGE_DEPTH = 4;

	// field order, shared by all three pages
	localparam logic [FIELD_W-1:0] FIELD_SEC = 2'd0;
	localparam logic [FIELD_W-1:0] FIELD_MIN = 2'd1;
	localparam logic [FIELD_W-1:0] FIELD_HOUR = 2'd2;
	localparam logic [FIELD_W-1:0] FIELD_DAY = 2'd3;

	// last BCD value of each field before rollover
	localparam logic [DATA_W-1:0] SEC_LAST = 8'h59;
	localparam logic [DATA_W-1:0] MIN_LAST = 8'h59;
	localparam logic [DATA_W-1:0] HOUR_LAST = 8'h23;
	localparam logic [DATA_W-1:0] DAY_LAST = 8'h99;

	// short second for simulation
	localparam int TICKS_PER_SEC_DEFAULT = 32;

	typedef enum logic [0:0] {KEEP_IDLE, KEEP_WRITE} keeperState_t;

	typedef enum logic [1:0] {SCAN_IDLE, SCAN_READ, SCAN_COMPARE, SCAN_LAP} scanState_t;

endpackage

`default_nettype wire

// ==== hdl/timeKeeper.sv ====
`default_nettype none
`timescale 1ns/1ns

module timeKeeper #(
	parameter int TICKS_PER_SEC = rtcPkg::TICKS_PER_SEC_DEFAULT
) (
	input wire clk,
	input wire reset,
	input wire setStrobe,
	input wire [rtcPkg::FIELD_W-1:0] setField,
	input wire [rtcPkg::DATA_W-1:0] setValue,
	output logic writeStrobe,
	output logic [rtcPkg::FIELD_W-1:0] writeField,
	output logic [rtcPkg::DATA_W-1:0] writeData,
	output logic secondDone,
	output logic [rtcPkg::DATA_W-1:0] seconds,
	output logic [rtcPkg::DATA_W-1:0] minutes,
	output logic [rtcPkg::DATA_W-1:0] hours,
	output logic [rtcPkg::DATA_W-1:0] days
);

	import rtcPkg::*;

	localparam int TICK_W = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;

	logic [TICK_W-1:0] tickCount;
	logic tickLast;
	keeperState_t state;
	logic [FIELD_W-1:0] writeIndex;

	// two-digit BCD increment with wrap at lastValue
	function automatic logic [DATA_W-1:0] bcdNext(input logic [DATA_W-1:0] value,
		input logic [DATA_W-1:0] lastValue);
		if (value == lastValue)
			return '0;
		else if (value[3:0] == 4'd9)
			return {value[DATA_W-1:4] + 4'd1, 4'd0};
		else
			return value + 1'b1;
	endfunction

	assign tickLast = (tickCount == TICK_W'(TICKS_PER_SEC - 1));

	//////////////////////////////////////////////////
	// tick counter and BCD time
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			tickCount <= '0;
			seconds <= '0;
			minutes <= '0;
			hours <= '0;
			days <= '0;
		end
		else if (setStrobe)
		begin
			// a set restarts the second
			tickCount <= '0;
			case (setField)
				FIELD_SEC: seconds <= setValue;
				FIELD_MIN: minutes <= setValue;
				FIELD_HOUR: hours <= setValue;
				default: days <= setValue;
			endcase
		end
		else if (tickLast)
		begin
			tickCount <= '0;
			seconds <= bcdNext(seconds, SEC_LAST);
			if (seconds == SEC_LAST)
			begin
				minutes <= bcdNext(minutes, MIN_LAST);
				if (minutes == MIN_LAST)
				begin
					hours <= bcdNext(hours, HOUR_LAST);
					if (hours == HOUR_LAST)
						days <= bcdNext(days, DAY_LAST);
				end
			end
		end
		else
			tickCount <= tickCount + 1'b1;
	end

	//////////////////////////////////////////////////
	// write-back of the four fields into the bank
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= KEEP_IDLE;
			writeIndex <= FIELD_SEC;
			secondDone <= 1'b0;
		end
		else
		begin
			// pulse once the day field has gone out
			secondDone <= (state == KEEP_WRITE) && (writeIndex == FIELD_DAY);
			if (setStrobe || tickLast)
			begin
				state <= KEEP_WRITE;
				writeIndex <= FIELD_SEC;
			end
			else if (state == KEEP_WRITE)
			begin
				if (writeIndex == FIELD_DAY)
					state <= KEEP_IDLE;
				writeIndex <= writeIndex + 1'b1;
			end
		end
	end

	assign writeStrobe = (state == KEEP_WRITE);
	assign writeField = writeIndex;

	always_comb
	begin
		case (writeIndex)
			FIELD_SEC: writeData = seconds;
			FIELD_MIN: writeData = minutes;
			FIELD_HOUR: writeData = hours;
			default: writeData = days;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/timeBank.sv ====
`default_nettype none
`timescale 1ns/1ns

module timeBank (
	input wire clk,
	input wire reset,
	input wire writeStrobe,
	input wire [rtcPkg::FIELD_W-1:0] writeField,
	input wire [rtcPkg::DATA_W-1:0] writeData,
	input wire lapCapture,
	input wire alarmCapture,
	input wire alarmRead,
	input wire [rtcPkg::FIELD_W-1:0] alarmField,
	input wire lapRead,
	input wire [rtcPkg::FIELD_W-1:0] lapField,
	output logic [rtcPkg::DATA_W-1:0] alarmData,
	output logic [rtcPkg::DATA_W-1:0] lapWord
);

	import rtcPkg::*;

	logic [DATA_W-1:0] livePage [PAGE_DEPTH];
	logic [DATA_W-1:0] alarmPage [PAGE_DEPTH];
	logic [DATA_W-1:0] lapPage [PAGE_DEPTH];

	//////////////////////////////////////////////////
	// page storage
	//////////////////////////////////////////////////

	// copies take the live page as it was before this edge's write
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < PAGE_DEPTH; i++)
			begin
				livePage[i] <= '0;
				alarmPage[i] <= '0;
				lapPage[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < PAGE_DEPTH; i++)
			begin
				if (lapCapture)
					lapPage[i] <= livePage[i];
				if (alarmCapture)
					alarmPage[i] <= livePage[i];
			end
			if (writeStrobe)
				livePage[writeField] <= writeData;
		end
	end

	//////////////////////////////////////////////////
	// read ports, alarm side has priority
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			alarmData <= '0;
			lapWord <= '0;
		end
		else
		begin
			alarmData <= alarmRead ? alarmPage[alarmField] : '0;
			lapWord <= (lapRead && !alarmRead) ? lapPage[lapField] : '0;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/alarmScanner.sv ====
`default_nettype none
`timescale 1ns/1ns

module alarmScanner (
	input wire clk,
	input wire reset,
	input wire secondDone,
	input wire [rtcPkg::DATA_W-1:0] seconds,
	input wire [rtcPkg::DATA_W-1:0] minutes,
	input wire [rtcPkg::DATA_W-1:0] hours,
	input wire alarmEnable,
	input wire lapRequest,
	input wire [rtcPkg::FIELD_W-1:0] lapRequestField,
	input wire [rtcPkg::DATA_W-1:0] alarmData,
	input wire [rtcPkg::DATA_W-1:0] lapWord,
	output logic alarmRead,
	output logic [rtcPkg::FIELD_W-1:0] alarmField,
	output logic lapRead,
	output logic [rtcPkg::FIELD_W-1:0] lapField,
	output logic alarmHit,
	output logic lapValid,
	output logic [rtcPkg::DATA_W-1:0] lapData
);

	import rtcPkg::*;

	scanState_t state;
	logic [FIELD_W-1:0] readIndex;
	logic matchAcc;
	logic lapPending;
	logic [FIELD_W-1:0] lapSel;
	logic lapFetched;
	logic acceptRequest;

	// a request is dropped while another one waits
	assign acceptRequest = lapRequest && !lapPending;

	//////////////////////////////////////////////////
	// scan and lap sequencing
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= SCAN_IDLE;
			readIndex <= FIELD_SEC;
			matchAcc <= 1'b0;
			lapPending <= 1'b0;
			lapSel <= FIELD_SEC;
			alarmHit <= 1'b0;
		end
		else
		begin
			alarmHit <= 1'b0;
			if (acceptRequest)
			begin
				lapPending <= 1'b1;
				lapSel <= lapRequestField;
			end
			case (state)
				SCAN_IDLE:
				begin
					if (secondDone)
					begin
						state <= SCAN_READ;
						readIndex <= FIELD_SEC;
					end
					else if (lapPending || lapRequest)
					begin
						// served now, so nothing stays pending
						state <= SCAN_LAP;
						lapPending <= 1'b0;
					end
				end
				SCAN_READ:
				begin
					// alarmData lags the field address by one cycle
					if (readIndex == FIELD_MIN)
						matchAcc <= (alarmData == seconds);
					else if (readIndex == FIELD_HOUR)
						matchAcc <= matchAcc && (alarmData == minutes);
					if (readIndex == FIELD_HOUR)
						state <= SCAN_COMPARE;
					readIndex <= readIndex + 1'b1;
				end
				SCAN_COMPARE:
				begin
					alarmHit <= alarmEnable && matchAcc && (alarmData == hours);
					state <= SCAN_IDLE;
				end
				default:
				begin
					if (secondDone)
					begin
						state <= SCAN_READ;
						readIndex <= FIELD_SEC;
					end
					else
						state <= SCAN_IDLE;
				end
			endcase
		end
	end

	assign alarmRead = (state == SCAN_READ);
	assign alarmField = readIndex;
	assign lapRead = (state == SCAN_LAP);
	assign lapField = lapSel;

	//////////////////////////////////////////////////
	// lap result
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			lapFetched <= 1'b0;
			lapValid <= 1'b0;
			lapData <= '0;
		end
		else
		begin
			lapFetched <= lapRead;
			lapValid <= lapFetched;
			if (lapFetched)
				lapData <= lapWord;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/rtcTop.sv ====
`default_nettype none
`timescale 1ns/1ns

module rtcTop #(
	parameter int TICKS_PER_SEC = rtcPkg::TICKS_PER_SEC_DEFAULT
) (
	input wire clk,
	input wire reset,
	input wire setStrobe,
	input wire [rtcPkg::FIELD_W-1:0] setField,
	input wire [rtcPkg::DATA_W-1:0] setValue,
	input wire lapCapture,
	input wire alarmCapture,
	input wire alarmEnable,
	input wire lapRequest,
	input wire [rtcPkg::FIELD_W-1:0] lapRequestField,
	output wire [rtcPkg::DATA_W-1:0] seconds,
	output wire [rtcPkg::DATA_W-1:0] minutes,
	output wire [rtcPkg::DATA_W-1:0] hours,
	output wire [rtcPkg::DATA_W-1:0] days,
	output wire alarmHit,
	output wire lapValid,
	output wire [rtcPkg::DATA_W-1:0] lapData
);

	import rtcPkg::*;

	// keeper to bank
	wire writeStrobe;
	wire [FIELD_W-1:0] writeField;
	wire [DATA_W-1:0] writeData;
	wire secondDone;

	// scanner to bank and back
	wire alarmRead;
	wire [FIELD_W-1:0] alarmField;
	wire [DATA_W-1:0] alarmData;
	wire lapRead;
	wire [FIELD_W-1:0] lapField;
	wire [DATA_W-1:0] lapWord;

	timeKeeper #(
		.TICKS_PER_SEC(TICKS_PER_SEC)
	) keeper (
		.clk(clk),
		.reset(reset),
		.setStrobe(setStrobe),
		.setField(setField),
		.setValue(setValue),
		.writeStrobe(writeStrobe),
		.writeField(writeField),
		.writeData(writeData),
		.secondDone(secondDone),
		.seconds(seconds),
		.minutes(minutes),
		.hours(hours),
		.days(days)
	);

	timeBank bank (
		.clk(clk),
		.reset(reset),
		.writeStrobe(writeStrobe),
		.writeField(writeField),
		.writeData(writeData),
		.lapCapture(lapCapture),
		.alarmCapture(alarmCapture),
		.alarmRead(alarmRead),
		.alarmField(alarmField),
		.lapRead(lapRead),
		.lapField(lapField),
		.alarmData(alarmData),
		.lapWord(lapWord)
	);

	alarmScanner scanner (
		.clk(clk),
		.reset(reset),
		.secondDone(secondDone),
		.seconds(seconds),
		.minutes(minutes),
		.hours(hours),
		.alarmEnable(alarmEnable),
		.lapRequest(lapRequest),
		.lapRequestField(lapRequestField),
		.alarmData(alarmData),
		.lapWord(lapWord),
		.alarmRead(alarmRead),
		.alarmField(alarmField),
		.lapRead(lapRead),
		.lapField(lapField),
		.alarmHit(alarmHit),
		.lapValid(lapValid),
		.lapData(lapData)
	);

endmodule

`default_nettype wire

// ==== dv/rtcTopTb.sv ====
`default_nettype none
`timescale 1ns/1ns

module rtcTopTb;

	import rtcPkg::*;

	localparam int TICKS = TICKS_PER_SEC_DEFAULT;
	localparam int WAIT_LIMIT = 4 * TICKS;

	logic clk;
	logic reset;
	logic setStrobe;
	logic [FIELD_W-1:0] setField;
	logic [DATA_W-1:0] setValue;
	logic lapCapture;
	logic alarmCapture;
	logic alarmEnable;
	logic lapRequest;
	logic [FIELD_W-1:0] lapRequestField;
	wire [DATA_W-1:0] seconds;
	wire [DATA_W-1:0] minutes;
	wire [DATA_W-1:0] hours;
	wire [DATA_W-1:0] days;
	wire alarmHit;
	wire lapValid;
	wire [DATA_W-1:0] lapData;

	// reference model state
	logic [DATA_W-1:0] modelSec;
	logic [DATA_W-1:0] modelMin;
	logic [DATA_W-1:0] modelHour;
	logic [DATA_W-1:0] modelDay;
	logic [DATA_W-1:0] alarmSec;
	logic [DATA_W-1:0] alarmMin;
	logic [DATA_W-1:0] alarmHour;
	logic [DATA_W-1:0] lapModel [PAGE_DEPTH];
	logic [DATA_W-1:0] expectedLap;
	int modelTick;
	int sinceStart;
	logic tickPulse;
	logic expectHit;
	int hitCount;
	int failCount = 0;

	// request bookkeeping, driven by the stimulus
	logic lapOutstanding;
	logic idleRequest;
	logic [FIELD_W-1:0] pendingField;

	rtcTop #(
		.TICKS_PER_SEC(TICKS_PER_SEC_DEFAULT)
	) DUT (
		.clk(clk),
		.reset(reset),
		.setStrobe(setStrobe),
		.setField(setField),
		.setValue(setValue),
		.lapCapture(lapCapture),
		.alarmCapture(alarmCapture),
		.alarmEnable(alarmEnable),
		.lapRequest(lapRequest),
		.lapRequestField(lapRequestField),
		.seconds(seconds),
		.minutes(minutes),
		.hours(hours),
		.days(days),
		.alarmHit(alarmHit),
		.lapValid(lapValid),
		.lapData(lapData)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic int fromBcd(input logic [DATA_W-1:0] value);
		return int'(value[7:4]) * 10 + int'(value[3:0]);
	endfunction

	function automatic logic [DATA_W-1:0] toBcd(input int value);
		return {4'(value / 10), 4'(value % 10)};
	endfunction

	function automatic logic [DATA_W-1:0] nextBcd(input logic [DATA_W-1:0] value,
		input int limit);
		return (fromBcd(value) == limit) ? toBcd(0) : toBcd(fromBcd(value) + 1);
	endfunction

	//////////////////////////////////////////////////
	// reference time model
	//////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (reset)
		begin
			modelTick <= 0;
			sinceStart <= 0;
			tickPulse <= 1'b0;
			expectHit <= 1'b0;
			{modelSec, modelMin, modelHour, modelDay} <= '0;
			{alarmSec, alarmMin, alarmHour} <= '0;
			for (int i = 0; i < PAGE_DEPTH; i++)
				lapModel[i] <= '0;
		end
		else
		begin
			tickPulse <= 1'b0;
			// captures happen only while the live page equals the model time
			if (lapCapture)
			begin
				lapModel[FIELD_SEC] <= modelSec;
				lapModel[FIELD_MIN] <= modelMin;
				lapModel[FIELD_HOUR] <= modelHour;
				lapModel[FIELD_DAY] <= modelDay;
			end
			if (alarmCapture)
				{alarmSec, alarmMin, alarmHour} <= {modelSec, modelMin, modelHour};
			// four writes, secondDone, then five cycles to the hit
			expectHit <= (sinceStart == 9) && alarmEnable && (modelSec == alarmSec)
				&& (modelMin == alarmMin) && (modelHour == alarmHour);
			if (setStrobe)
			begin
				modelTick <= 0;
				sinceStart <= 1;
				case (setField)
					FIELD_SEC: modelSec <= setValue;
					FIELD_MIN: modelMin <= setValue;
					FIELD_HOUR: modelHour <= setValue;
					default: modelDay <= setValue;
				endcase
			end
			else if (modelTick == TICKS - 1)
			begin
				modelTick <= 0;
				sinceStart <= 1;
				tickPulse <= 1'b1;
				modelSec <= nextBcd(modelSec, 59);
				if (fromBcd(modelSec) == 59)
				begin
					modelMin <= nextBcd(modelMin, 59);
					if (fromBcd(modelMin) == 59)
					begin
						modelHour <= nextBcd(modelHour, 23);
						if (fromBcd(modelHour) == 23)
							modelDay <= nextBcd(modelDay, 99);
					end
				end
			end
			else
			begin
				modelTick <= modelTick + 1;
				if (sinceStart != 0 && sinceStart < 40)
					sinceStart <= sinceStart + 1;
			end
		end
	end

	always @(posedge clk)
	begin
		if (reset)
			hitCount <= 0;
		else if (alarmHit)
			hitCount <= hitCount + 1;
	end

	assign expectedLap = lapModel[pendingField];

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	timeFollowsModel: assert property (@(posedge clk) disable iff (reset)
		seconds == modelSec && minutes == modelMin && hours == modelHour && days == modelDay)
		else failValue($sformatf("time %h:%h:%h day %h, expected %h:%h:%h day %h",
			$sampled(hours), $sampled(minutes), $sampled(seconds), $sampled(days),
			$sampled(modelHour), $sampled(modelMin), $sampled(modelSec), $sampled(modelDay)));

	alarmHitTiming: assert property (@(posedge clk) disable iff (reset)
		alarmHit == expectHit)
		else failValue($sformatf("alarmHit is %b, expected %b",
			$sampled(alarmHit), $sampled(expectHit)));

	lapDataMatches: assert property (@(posedge clk) disable iff (reset)
		lapValid |-> lapOutstanding && lapData == expectedLap)
		else failValue($sformatf("lapValid with lapData %h, expected %h for field %0d",
			$sampled(lapData), $sampled(expectedLap), $sampled(pendingField)));

	// an idle request is answered two cycles after its edge
	idleLapLatency: assert property (@(posedge clk) disable iff (reset)
		lapRequest && idleRequest |-> ##1 !lapValid ##1 !lapValid ##1 lapValid)
		else failValue("lapValid not exactly two cycles after an idle lap request");

	task automatic abortRun();
		$display("Testbench failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic failValue(input string message);
		failCount++;
		$display("Error at %0t ns: %s", $time, message);
		abortRun();
	endtask

	task automatic failTimeout(input string signalName);
		$display("Timed out at %0t ns waiting for %s", $time, signalName);
		abortRun();
	endtask

	//////////////////////////////////////////////////
	// stimulus tasks
	//////////////////////////////////////////////////

	// middle of a second, after write-back and alarm scan
	task automatic waitQuiet();
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (!(modelTick >= 12 && modelTick <= TICKS - 8))
		begin
			@(posedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT)
				failTimeout("the quiet part of a second");
		end
	endtask

	task automatic waitSeconds(input int secondCount);
		int cycles;
		for (int i = 0; i < secondCount; i++)
		begin
			cycles = 0;
			@(posedge clk);
			while (!tickPulse)
			begin
				@(posedge clk);
				cycles++;
				if (cycles > WAIT_LIMIT)
					failTimeout("the next second tick");
			end
		end
	endtask

	task automatic setTime(input logic [DATA_W-1:0] sec, input logic [DATA_W-1:0] min,
		input logic [DATA_W-1:0] hour, input logic [DATA_W-1:0] day);
		logic [DATA_W-1:0] values [PAGE_DEPTH];
		values[FIELD_SEC] = sec;
		values[FIELD_MIN] = min;
		values[FIELD_HOUR] = hour;
		values[FIELD_DAY] = day;
		waitQuiet();
		for (int i = 0; i < PAGE_DEPTH; i++)
		begin
			@(posedge clk);
			setStrobe <= 1'b1;
			setField <= FIELD_W'(i);
			setValue <= values[i];
		end
		@(posedge clk);
		setStrobe <= 1'b0;
	endtask

	task automatic pulseCapture(input logic toAlarm);
		waitQuiet();
		repeat ($urandom_range(7, 0)) @(posedge clk);
		@(posedge clk);
		if (toAlarm)
			alarmCapture <= 1'b1;
		else
			lapCapture <= 1'b1;
		@(posedge clk);
		alarmCapture <= 1'b0;
		lapCapture <= 1'b0;
	endtask

	task automatic requestLap(input logic [FIELD_W-1:0] field, input logic fromIdle);
		int cycles;
		cycles = 0;
		@(posedge clk);
		lapRequest <= 1'b1;
		lapRequestField <= field;
		idleRequest <= fromIdle;
		pendingField <= field;
		lapOutstanding <= 1'b1;
		@(posedge clk);
		lapRequest <= 1'b0;
		idleRequest <= 1'b0;
		while (!lapValid)
		begin
			@(posedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT)
				failTimeout("lapValid");
		end
		lapOutstanding <= 1'b0;
	endtask

	task automatic runAlarmCase(input logic enable, input int expectedHits);
		int startHits;
		@(posedge clk);
		alarmEnable <= enable;
		// seconds kept clear of the minute edge
		setTime(toBcd($urandom_range(50, 10)), toBcd($urandom_range(59, 0)),
			toBcd($urandom_range(23, 0)), toBcd($urandom_range(99, 0)));
		pulseCapture(1'b1);
		// model alarm fields settle one edge after the capture
		@(posedge clk);
		startHits = hitCount;
		setTime(toBcd(fromBcd(alarmSec) - 3), alarmMin, alarmHour, modelDay);
		waitSeconds(6);
		waitQuiet();
		assert (hitCount - startHits == expectedHits)
			else failValue($sformatf("%0d alarm hits, expected %0d",
				hitCount - startHits, expectedHits));
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin
		int pick;
		logic [FIELD_W-1:0] order [PAGE_DEPTH];
		logic [FIELD_W-1:0] swap;
		void'($urandom(32'h46fd_3243));
		reset = 1'b1;
		setStrobe = 1'b0;
		setField = '0;
		setValue = '0;
		lapCapture = 1'b0;
		alarmCapture = 1'b0;
		alarmEnable = 1'b0;
		lapRequest = 1'b0;
		lapRequestField = '0;
		lapOutstanding = 1'b0;
		idleRequest = 1'b0;
		pendingField = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		// empty lap page reads back zero
		for (int f = 0; f < PAGE_DEPTH; f++)
		begin
			waitQuiet();
			requestLap(FIELD_W'(f), 1'b1);
		end

		// rollover of every field
		setTime(8'h57, 8'h59, 8'h23, 8'h99);
		waitSeconds(5);
		assert (seconds == 8'h02 && minutes == 8'h00 && hours == 8'h00 && days == 8'h00)
			else failValue("time after the day rollover is not 00:00:02 on day 00");

		// lap capture, fields read in random order
		setTime(toBcd($urandom_range(50, 0)), toBcd($urandom_range(59, 1)),
			toBcd($urandom_range(23, 1)), toBcd($urandom_range(99, 1)));
		waitSeconds($urandom_range(3, 1));
		pulseCapture(1'b0);
		for (int i = 0; i < PAGE_DEPTH; i++)
			order[i] = FIELD_W'(i);
		for (int i = PAGE_DEPTH - 1; i > 0; i--)
		begin
			pick = $urandom_range(i, 0);
			swap = order[i];
			order[i] = order[pick];
			order[pick] = swap;
		end
		for (int i = 0; i < PAGE_DEPTH; i++)
		begin
			waitQuiet();
			requestLap(order[i], 1'b1);
		end

		// request lands while the alarm scan runs
		waitSeconds(1);
		repeat ($urandom_range(6, 2)) @(posedge clk);
		requestLap(FIELD_W'($urandom_range(3, 0)), 1'b0);

		runAlarmCase(1'b1, 1);
		runAlarmCase(1'b0, 0);

		if (failCount == 0)
		begin
			$display("Testbench passed");
			$finish;
		end
		else
			abortRun();
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/rtcPkg.sv
hdl/timeKeeper.sv
hdl/timeBank.sv
hdl/alarmScanner.sv
hdl/rtcTop.sv
dv/rtcTopTb.sv

// ==== Bender.yml ====
package:
  name: rtcSubsystem

sources:
  - hdl/rtcPkg.sv
  - hdl/timeKeeper.sv
  - hdl/timeBank.sv
  - hdl/alarmScanner.sv
  - hdl/rtcTop.sv
  - target: test
    files:
      - dv/rtcTopTb.sv
